// File: async_fifo.f
src/afifo_pkg.sv
src/ram_if.sv
src/dual_port_ram.sv
src/wr_ptr_ctrl.sv
src/rd_ptr_ctrl.sv
src/async_fifo.sv
verif/async_fifo_checker.sv
verif/async_fifo_tb.sv

// File: verif/async_fifo_tb.sv
`timescale 1ns/10ps

module async_fifo_tb
  import afifo_pkg::*;
();

  localparam int DATA_WIDTH     = DEF_DATA_WIDTH;
  localparam int FIFO_DEPTH     = DEF_FIFO_DEPTH;
  localparam int AFULL_LEVEL    = DEF_AFULL_LEVEL;
  localparam int AEMPTY_LEVEL   = DEF_AEMPTY_LEVEL;
  localparam int RANDOM_CYCLES  = 600;
  localparam int TEST_CYCLES    = 2000;  // upper bound of the whole sequence in rd_clk cycles.
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  wr_rst_n;
  logic                  rd_rst_n;
  logic                  wr_en;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  integer                seed = 11;
  logic [DATA_WIDTH-1:0] ref_q [$];  // words of accepted writes, oldest first.
  logic [DATA_WIDTH-1:0] exp_rd_data = '0;
  logic                  wr_en_pat   [RANDOM_CYCLES];
  logic                  rd_en_pat   [RANDOM_CYCLES];
  logic [DATA_WIDTH-1:0] wr_data_pat [RANDOM_CYCLES];
  int                    levels [8] = '{1, 2, 3, 8, 13, 14, 15, 16};
  int                    data_errors   = 0;
  int                    flag_errors   = 0;
  int                    other_errors  = 0;
  int                    assert_errors = 0;
  int                    cycle_count   = 0;

  always #10 rd_clk = ~rd_clk;
  always #7 wr_clk = ~wr_clk;  // write side runs faster than the read side.

  async_fifo #(
    .DATA_WIDTH   (DATA_WIDTH),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_LEVEL  (AFULL_LEVEL),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic logic [DATA_WIDTH-1:0] next_expected_word();
    return ref_q.pop_front();
  endfunction

  // flags as {full, afull, empty, aempty} once both pointers have crossed.
  function automatic logic [3:0] settled_flags(input int count);
    logic [3:0] flags;
    flags[3] = (count >= FIFO_DEPTH);
    flags[2] = (count >= AFULL_LEVEL);
    flags[1] = (count == 0);
    flags[0] = (count <= AEMPTY_LEVEL);
    return flags;
  endfunction

  task automatic expect_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
      flag_errors++;
    end
  endtask

  task automatic compare_all_flags();
    logic [3:0] exp;
    exp = settled_flags(ref_q.size());
    expect_flag("full", exp[3], full);
    expect_flag("afull", exp[2], afull);
    expect_flag("empty", exp[1], empty);
    expect_flag("aempty", exp[0], aempty);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic apply_reset();
    fork
      begin
        repeat (5) @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (5) @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join
  endtask

  // the write flags follow the queue at once while the reader is idle.
  task automatic write_burst(input int n);
    logic [3:0] exp;
    for (int i = 0; i <= n; i++) begin
      @(negedge wr_clk);
      exp = settled_flags(ref_q.size());
      expect_flag("full", exp[3], full);
      expect_flag("afull", exp[2], afull);
      wr_en   = (i < n);
      wr_data = DATA_WIDTH'($random(seed));
    end
  endtask

  task automatic read_burst(input int n);
    logic [3:0] exp;
    for (int i = 0; i <= n; i++) begin
      @(negedge rd_clk);
      exp = settled_flags(ref_q.size());
      expect_flag("empty", exp[1], empty);
      expect_flag("aempty", exp[0], aempty);
      rd_en = (i < n);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge rd_clk);
  endtask

  task automatic make_random_patterns();
    int r;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      r = $random(seed);
      wr_en_pat[i]   = (r[1:0] != 2'b00);
      rd_en_pat[i]   = (r[3:2] != 2'b00);
      wr_data_pat[i] = DATA_WIDTH'($random(seed));
    end
  endtask

  task automatic run_random_traffic();
    fork
      begin
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
          @(negedge wr_clk);
          wr_en   = wr_en_pat[i];
          wr_data = wr_data_pat[i];
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
      end
      begin
        for (int j = 0; j < RANDOM_CYCLES; j++) begin
          @(negedge rd_clk);
          rd_en = rd_en_pat[j];
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
      end
    join
  endtask

  // ----------------------------------------
  // monitors and compare
  // ----------------------------------------
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      ref_q.push_back(wr_data);
    end
  end

  // rd_data still shows the word of the previous accepted read here.
  always @(posedge rd_clk) begin
    if (rd_rst_n) begin
      assert (rd_data === exp_rd_data) else begin
        $display("FAIL at %0t: rd_data expected %h, got %h", $time, exp_rd_data, rd_data);
        data_errors++;
      end
      if (rd_en && !empty) begin
        assert (ref_q.size() > 0) else begin
          $display("ERROR at %0t: a read was accepted with no written word left", $time);
          other_errors++;
        end
        if (ref_q.size() > 0) begin
          exp_rd_data = next_expected_word();
        end
      end
    end
  end

  always @(posedge rd_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    $timeformat(-9, 1, " ns", 0);
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    apply_reset();

    @(negedge rd_clk);
    compare_all_flags();
    assert (rd_data === '0) else begin
      $display("FAIL at %0t: rd_data expected %h, got %h", $time, '0, rd_data);
      data_errors++;
    end

    // fill past full, then drain past empty.
    write_burst(FIFO_DEPTH + 4);
    idle_cycles(10);
    compare_all_flags();
    read_burst(FIFO_DEPTH + 4);
    idle_cycles(10);
    compare_all_flags();

    foreach (levels[i]) begin
      write_burst(levels[i]);
      idle_cycles(10);
      compare_all_flags();
      read_burst(levels[i]);
      idle_cycles(10);
      compare_all_flags();
    end

    make_random_patterns();
    run_random_traffic();
    idle_cycles(10);
    read_burst(ref_q.size() + 2);
    idle_cycles(10);
    compare_all_flags();
    assert (ref_q.size() == 0) else begin
      $display("ERROR: %0d written words were never read back", ref_q.size());
      other_errors++;
    end

    assert_errors = i_async_fifo.i_async_fifo_checker.fail_count;
    $display("errors: data %0d, flag %0d, other %0d, assertion %0d",
             data_errors, flag_errors, other_errors, assert_errors);
    if (data_errors + flag_errors + other_errors + assert_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verif/async_fifo_checker.sv
`timescale 1ns/10ps

module async_fifo_checker #(
  parameter int FIFO_DEPTH = 16,
  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH) + 1
) (
  input logic                 wr_clk,
  input logic                 wr_rst_n,
  input logic                 rd_clk,
  input logic                 rd_rst_n,
  input logic                 full,
  input logic                 afull,
  input logic                 empty,
  input logic                 aempty,
  input logic                 ram_wr_en,
  input logic [PTR_WIDTH-1:0] wr_ptr,
  input logic [PTR_WIDTH-1:0] rd_ptr
);

  int fail_count = 0;  // number of failed assertions.

  logic [PTR_WIDTH-1:0] used_words;  // true fill level from both binary pointers.

  assign used_words = wr_ptr - rd_ptr;

  // ----------------------------------------
  // write domain
  // ----------------------------------------
  full_implies_afull: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull
  ) else begin
    $error("full is high while afull is low");
    fail_count++;
  end

  // a RAM write with every slot in use would overwrite unread data.
  no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n || !rd_rst_n)
      ram_wr_en |-> (used_words < FIFO_DEPTH)
  ) else begin
    $error("the RAM was written while the FIFO was full");
    fail_count++;
  end

  // ----------------------------------------
  // read domain
  // ----------------------------------------
  empty_implies_aempty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty
  ) else begin
    $error("empty is high while aempty is low");
    fail_count++;
  end

  not_full_and_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n || !wr_rst_n) !(full && empty)
  ) else begin
    $error("full and empty are high at the same time");
    fail_count++;
  end

endmodule

bind async_fifo async_fifo_checker #(
  .FIFO_DEPTH (FIFO_DEPTH)
) i_async_fifo_checker (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .full      (full),
  .afull     (afull),
  .empty     (empty),
  .aempty    (aempty),
  .ram_wr_en (i_ram_if.wr_en),
  .wr_ptr    (i_wr_ptr_ctrl.wr_bin),
  .rd_ptr    (i_rd_ptr_ctrl.rd_bin)
);

// File: src/async_fifo.sv
`timescale 1ns/10ps

module async_fifo
  import afifo_pkg::*;
#(
  parameter int DATA_WIDTH   = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH   = DEF_FIFO_DEPTH,
  parameter int AFULL_LEVEL  = DEF_AFULL_LEVEL,
  parameter int AEMPTY_LEVEL = DEF_AEMPTY_LEVEL
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // gray pointers crossing between the two clock domains.
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] rd_gray;

  ram_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_ram_if ();

  // ----------------------------------------
  // write and read domain control
  // ----------------------------------------
  wr_ptr_ctrl #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .AFULL_LEVEL (AFULL_LEVEL)
  ) i_wr_ptr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_gray  (rd_gray),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull),
    .ram      (i_ram_if)
  );

  rd_ptr_ctrl #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) i_rd_ptr_ctrl (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty),
    .ram      (i_ram_if)
  );

  dual_port_ram #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dual_port_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram      (i_ram_if)
  );

  assign rd_data = i_ram_if.rd_data;

endmodule

// File: src/rd_ptr_ctrl.sv
`timescale 1ns/10ps

module rd_ptr_ctrl
  import afifo_pkg::*;
#(
  parameter int FIFO_DEPTH   = DEF_FIFO_DEPTH,
  parameter int AEMPTY_LEVEL = DEF_AEMPTY_LEVEL,
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH)
) (
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  input  logic [ADDR_WIDTH:0] wr_gray,
  output logic [ADDR_WIDTH:0] rd_gray,
  output logic                empty,
  output logic                aempty,
  ram_if.rd                   ram
);

  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  logic                 rd_accept;
  logic [ADDR_WIDTH:0]  rd_bin;
  logic [ADDR_WIDTH:0]  rd_bin_next;
  logic [ADDR_WIDTH:0]  rd_gray_next;
  logic [15:0]          rd_gray_wide;
  logic [ADDR_WIDTH:0]  wr_gray_s1;
  logic [ADDR_WIDTH:0]  wr_gray_s2;
  logic [15:0]          wr_bin_wide;
  logic [ADDR_WIDTH:0]  wr_bin_sync;
  logic [ADDR_WIDTH:0]  used_next;
  logic                 empty_next;
  logic                 aempty_next;

  assign rd_accept   = rd_en & ~empty;
  assign rd_bin_next = rd_bin + PTR_WIDTH'(rd_accept);

  assign rd_gray_wide = bin2gray(16'(rd_bin_next));
  assign rd_gray_next = rd_gray_wide[ADDR_WIDTH:0];

  // ----------------------------------------
  // pointer registers and write-side sync
  // ----------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      rd_bin     <= rd_bin_next;
      rd_gray    <= rd_gray_next;
      wr_gray_s1 <= wr_gray;     // first stage may go metastable.
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_bin_wide = gray2bin(16'(wr_gray_s2));
  assign wr_bin_sync = wr_bin_wide[ADDR_WIDTH:0];
  assign used_next   = wr_bin_sync - rd_bin_next;

  // the next pointer is used so the last read raises empty at once.
  assign empty_next  = (rd_gray_next == wr_gray_s2);
  assign aempty_next = (used_next <= PTR_WIDTH'(AEMPTY_LEVEL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_next;
      aempty <= aempty_next;
    end
  end

  assign ram.rd_en   = rd_accept;
  assign ram.rd_addr = rd_bin[ADDR_WIDTH-1:0];

endmodule

// File: src/wr_ptr_ctrl.sv
`timescale 1ns/10ps

module wr_ptr_ctrl
  import afifo_pkg::*;
#(
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
  parameter int AFULL_LEVEL = DEF_AFULL_LEVEL,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic [ADDR_WIDTH:0]   rd_gray,
  output logic [ADDR_WIDTH:0]   wr_gray,
  output logic                  full,
  output logic                  afull,
  ram_if.wr                     ram
);

  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  logic                 wr_accept;
  logic [ADDR_WIDTH:0]  wr_bin;
  logic [ADDR_WIDTH:0]  wr_bin_next;
  logic [ADDR_WIDTH:0]  wr_gray_next;
  logic [15:0]          wr_gray_wide;
  logic [ADDR_WIDTH:0]  rd_gray_s1;
  logic [ADDR_WIDTH:0]  rd_gray_s2;
  logic [15:0]          rd_bin_wide;
  logic [ADDR_WIDTH:0]  rd_bin_sync;
  logic [ADDR_WIDTH:0]  used_next;
  logic                 full_next;
  logic                 afull_next;

  assign wr_accept   = wr_en & ~full;
  assign wr_bin_next = wr_bin + PTR_WIDTH'(wr_accept);

  assign wr_gray_wide = bin2gray(16'(wr_bin_next));
  assign wr_gray_next = wr_gray_wide[ADDR_WIDTH:0];

  // ----------------------------------------
  // pointer registers and read-side sync
  // ----------------------------------------
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      wr_bin     <= wr_bin_next;
      wr_gray    <= wr_gray_next;  // only one bit moves per write.
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_bin_wide = gray2bin(16'(rd_gray_s2));
  assign rd_bin_sync = rd_bin_wide[ADDR_WIDTH:0];
  assign used_next   = wr_bin_next - rd_bin_sync;

  // full means the writer is one lap ahead, so the two top gray bits differ.
  assign full_next  = (wr_gray_next ==
                       {~rd_gray_s2[ADDR_WIDTH:ADDR_WIDTH-1], rd_gray_s2[ADDR_WIDTH-2:0]});
  assign afull_next = (used_next >= PTR_WIDTH'(AFULL_LEVEL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_next;
      afull <= afull_next;
    end
  end

  assign ram.wr_en   = wr_accept;
  assign ram.wr_addr = wr_bin[ADDR_WIDTH-1:0];
  assign ram.wr_data = wr_data;

endmodule

// File: src/dual_port_ram.sv
`timescale 1ns/10ps

module dual_port_ram #(
  parameter int FIFO_DEPTH = 16,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic wr_clk,
  input  logic rd_clk,
  input  logic rd_rst_n,
  ram_if.ram   ram
);

  localparam int DATA_WIDTH = $bits(ram.rd_data);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [DATA_WIDTH-1:0] rd_q;

  // ----------------------------------------
  // write port
  // ----------------------------------------
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // ----------------------------------------
  // registered read port
  // ----------------------------------------
  // the output holds its last word until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_q <= '0;
    end else if (ram.rd_en) begin
      rd_q <= mem[ram.rd_addr];
    end
  end

  assign ram.rd_data = rd_q;

endmodule

// File: src/ram_if.sv
`timescale 1ns/10ps

interface ram_if #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
);

  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;

  // the write port lives in the write clock domain.
  modport wr (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport rd (
    output rd_en,
    output rd_addr
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: src/afifo_pkg.sv
package afifo_pkg;

  // ----------------------------------------
  // default geometry and flag levels
  // ----------------------------------------
  localparam int DEF_DATA_WIDTH   = 8;
  localparam int DEF_FIFO_DEPTH   = 16;
  localparam int DEF_AFULL_LEVEL  = 14;  // words stored before afull rises.
  localparam int DEF_AEMPTY_LEVEL = 2;   // words left when aempty rises.

  // ----------------------------------------
  // gray code conversion
  // ----------------------------------------
  // narrower pointers are zero extended by the caller and the result is sliced.
  function automatic logic [15:0] bin2gray(input logic [15:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [15:0] gray2bin(input logic [15:0] gray);
    logic [15:0] bin;
    bin[15] = gray[15];
    for (int i = 14; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // each binary bit folds in all gray bits above it.
    end
    return bin;
  endfunction

endpackage
